// ==== common/dwnld_map_pkg.sv ====
// download address map definitions
// loader byte address type, SDRAM bank index type and the
// marker used to switch off a region or a bank
// helper that tells whether a start address is in use

package dwnld_map_pkg;

    ////////////////////
    // loader side

    // the loader sends up to 32 MiB of ROM, one byte per address
    localparam int IOCTL_AW = 25;

    typedef logic [IOCTL_AW-1:0] ioctl_addr_t;

    ////////////////////
    // SDRAM banking

    // four banks, bank 0 always starts at part address zero
    localparam int BANK_W = 2;

    typedef logic [BANK_W-1:0] bank_t;

    ////////////////////
    // region markers

    // a start address of all ones means the region or bank does not exist
    localparam ioctl_addr_t ADDR_UNUSED = '1;

    // true when a start address was actually set by the core
    function automatic logic region_used(input ioctl_addr_t start);
        return start != ADDR_UNUSED;
    endfunction

endpackage

// ==== common/sdram_prog_pkg.sv ====
// SDRAM programming port definitions
// word address, write data and byte mask types
// byte mask encodings for low, high and both bytes

package sdram_prog_pkg;

    // 16-bit words, so 22 address bits cover 8 MiB per bank
    localparam int PROG_AW = 22;
    localparam int PROG_DW = 16;

    typedef logic [PROG_AW-1:0] prog_addr_t;
    typedef logic [PROG_DW-1:0] prog_data_t;

    // one mask bit per byte lane, active low
    typedef logic [1:0] prog_mask_t;

    ////////////////////
    // mask encodings

    // bit 0 guards the low byte, bit 1 the high byte
    localparam prog_mask_t MASK_LOW  = 2'b10;
    localparam prog_mask_t MASK_HIGH = 2'b01;
    // PROM bytes carry both lanes enabled
    localparam prog_mask_t MASK_BOTH = 2'b00;

endpackage

// ==== dwnld/rom_region_decode.sv ====
// first stage of the ROM download path
// drops the file header, splits bytes into PROM and SDRAM regions,
// picks the SDRAM bank and registers the decoded request

`timescale 1ns/1ps

module rom_region_decode #(
    parameter dwnld_map_pkg::ioctl_addr_t HEADER     = '0,
    parameter dwnld_map_pkg::ioctl_addr_t PROM_START = dwnld_map_pkg::ADDR_UNUSED,
    parameter dwnld_map_pkg::ioctl_addr_t BA1_START  = dwnld_map_pkg::ADDR_UNUSED,
    parameter dwnld_map_pkg::ioctl_addr_t BA2_START  = dwnld_map_pkg::ADDR_UNUSED,
    parameter dwnld_map_pkg::ioctl_addr_t BA3_START  = dwnld_map_pkg::ADDR_UNUSED
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  dwnld_map_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                 ioctl_data,
    input  logic                       ioctl_wr,
    output logic                       dec_valid,
    output logic                       dec_prom,
    output dwnld_map_pkg::bank_t       dec_bank,
    output sdram_prog_pkg::prog_addr_t dec_word,
    output logic                       dec_high,
    output logic [7:0]                 dec_data
);
    import dwnld_map_pkg::*;
    import sdram_prog_pkg::*;

    // which parts of the map the core actually uses
    localparam logic PROM_EN = region_used(PROM_START);
    localparam logic BA1_EN  = region_used(BA1_START);
    localparam logic BA2_EN  = region_used(BA2_START);
    localparam logic BA3_EN  = region_used(BA3_START);
    // without any bank start everything lands in bank 0
    localparam logic BA_EN   = BA1_EN || BA2_EN || BA3_EN;

    ioctl_addr_t part_addr;
    ioctl_addr_t offset;
    ioctl_addr_t eff_addr;
    bank_t       bank;
    logic        in_header;
    logic        is_prom;
    logic        accept;

    ////////////////////
    // header and region

    // the part address counts from the first byte after the header
    always_comb begin
        in_header = (HEADER != '0) && (ioctl_addr < HEADER);
        part_addr = ioctl_addr - HEADER;
        is_prom   = PROM_EN && (part_addr >= PROM_START);
    end

    // a byte is taken only while the loader is busy and past the header
    assign accept = ioctl_wr && downloading && !in_header;

    ////////////////////
    // bank select

    // banks are laid out in ascending order, so the highest start that
    // is not above the part address wins
    always_comb begin
        bank   = '0;
        offset = '0;
        if (BA_EN) begin
            if (BA3_EN && part_addr >= BA3_START) begin
                bank   = 2'd3;
                offset = BA3_START;
            end else if (BA2_EN && part_addr >= BA2_START) begin
                bank   = 2'd2;
                offset = BA2_START;
            end else if (BA1_EN && part_addr >= BA1_START) begin
                bank   = 2'd1;
                offset = BA1_START;
            end
        end
        // each bank is addressed from its own zero
        eff_addr = part_addr - offset;
    end

    ////////////////////
    // stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_prom  <= 1'b0;
            dec_bank  <= '0;
            dec_word  <= '0;
            dec_high  <= 1'b0;
            dec_data  <= '0;
        end else begin
            // one pulse per accepted byte
            dec_valid <= accept;
            if (accept) begin
                dec_prom <= is_prom;
                dec_bank <= bank;
                // PROM keeps the byte address, SDRAM gets a word address
                if (is_prom) begin
                    dec_word <= part_addr[PROG_AW-1:0];
                end else begin
                    dec_word <= eff_addr[PROG_AW:1];
                end
                // odd addresses go to the upper byte lane
                dec_high <= eff_addr[0];
                dec_data <= ioctl_data;
            end
        end
    end

endmodule

// ==== dwnld/prog_write_port.sv ====
// second stage of the ROM download path
// builds the SDRAM write request and keeps it up until the
// controller acknowledges, and strobes PROM writes for one cycle

`timescale 1ns/1ps

module prog_write_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       downloading,
    input  logic                       dec_valid,
    input  logic                       dec_prom,
    input  dwnld_map_pkg::bank_t       dec_bank,
    input  sdram_prog_pkg::prog_addr_t dec_word,
    input  logic                       dec_high,
    input  logic [7:0]                 dec_data,
    input  logic                       sdram_ack,
    output sdram_prog_pkg::prog_addr_t prog_addr,
    output sdram_prog_pkg::prog_data_t prog_data,
    output sdram_prog_pkg::prog_mask_t prog_mask,
    output dwnld_map_pkg::bank_t       prog_ba,
    output logic                       prog_we,
    output logic                       prom_we
);
    import sdram_prog_pkg::*;

    logic sdram_req;
    logic prom_req;

    // split the decoded byte by destination
    assign sdram_req = dec_valid && !dec_prom;
    assign prom_req  = dec_valid && dec_prom;

    ////////////////////
    // request payload

    // address, data and mask are shared by both destinations
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_addr <= '0;
            prog_data <= '0;
            prog_mask <= '0;
            prog_ba   <= '0;
        end else if (dec_valid) begin
            prog_addr <= dec_word;
            // the byte sits on both halves and the mask picks the lane
            prog_data <= {2{dec_data}};
            if (dec_prom) begin
                prog_mask <= MASK_BOTH;
            end else begin
                prog_mask <= dec_high ? MASK_HIGH : MASK_LOW;
                // the bank only moves with SDRAM requests
                prog_ba   <= dec_bank;
            end
        end
    end

    ////////////////////
    // write strobes

    // prog_we is a level that the SDRAM controller clears with its ack,
    // a new byte overrides a request still pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (sdram_req) begin
            prog_we <= 1'b1;
        end else if (prom_req) begin
            prog_we <= 1'b0;
        end else if (sdram_ack || !downloading) begin
            // the end of the download also drops a pending request
            prog_we <= 1'b0;
        end
    end

    // PROM memories latch on a single cycle pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prom_we <= 1'b0;
        end else begin
            prom_we <= prom_req;
        end
    end

endmodule

// ==== rtl/rom_dwnld_top.sv ====
// top level of the ROM download path
// owns the download map parameters and chains the decode stage
// into the SDRAM and PROM write port

`timescale 1ns/1ps

module rom_dwnld_top #(
    // leading bytes of the file that hold no ROM data
    parameter dwnld_map_pkg::ioctl_addr_t HEADER     = '0,
    // first PROM byte, counted after the header
    parameter dwnld_map_pkg::ioctl_addr_t PROM_START = dwnld_map_pkg::ADDR_UNUSED,
    // first byte of SDRAM banks 1 to 3
    parameter dwnld_map_pkg::ioctl_addr_t BA1_START  = dwnld_map_pkg::ADDR_UNUSED,
    parameter dwnld_map_pkg::ioctl_addr_t BA2_START  = dwnld_map_pkg::ADDR_UNUSED,
    parameter dwnld_map_pkg::ioctl_addr_t BA3_START  = dwnld_map_pkg::ADDR_UNUSED
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // loader byte stream
    input  logic                       downloading,
    input  dwnld_map_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]                 ioctl_data,
    input  logic                       ioctl_wr,
    // SDRAM programming port
    input  logic                       sdram_ack,
    output sdram_prog_pkg::prog_addr_t prog_addr,
    output sdram_prog_pkg::prog_data_t prog_data,
    output sdram_prog_pkg::prog_mask_t prog_mask,
    output dwnld_map_pkg::bank_t       prog_ba,
    output logic                       prog_we,
    // PROM write strobe
    output logic                       prom_we
);
    import dwnld_map_pkg::*;
    import sdram_prog_pkg::*;

    // decoded byte between the two stages
    logic       dec_valid;
    logic       dec_prom;
    bank_t      dec_bank;
    prog_addr_t dec_word;
    logic       dec_high;
    logic [7:0] dec_data;

    ////////////////////
    // stage 1

    rom_region_decode #(
        .HEADER     (HEADER),
        .PROM_START (PROM_START),
        .BA1_START  (BA1_START),
        .BA2_START  (BA2_START),
        .BA3_START  (BA3_START)
    ) u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .dec_valid   (dec_valid),
        .dec_prom    (dec_prom),
        .dec_bank    (dec_bank),
        .dec_word    (dec_word),
        .dec_high    (dec_high),
        .dec_data    (dec_data)
    );

    ////////////////////
    // stage 2

    prog_write_port u_write_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .dec_valid   (dec_valid),
        .dec_prom    (dec_prom),
        .dec_bank    (dec_bank),
        .dec_word    (dec_word),
        .dec_high    (dec_high),
        .dec_data    (dec_data),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

endmodule

// ==== tests/tb_rom_dwnld.sv ====
// directed testbench for the ROM download path
// clock and reset, LFSR byte source, SDRAM acknowledge model,
// reference address map, compare tasks and the test tasks

`timescale 1ns/1ps

module tb_rom_dwnld;
    import dwnld_map_pkg::*;
    import sdram_prog_pkg::*;

    // download map used for every test
    localparam ioctl_addr_t HDR     = 25'd16;
    localparam ioctl_addr_t PROM_ST = 25'h4000;
    localparam ioctl_addr_t BA1     = 25'h1000;
    localparam ioctl_addr_t BA2     = 25'h2000;
    localparam ioctl_addr_t BA3     = 25'h3000;
    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        sdram_ack;
    prog_addr_t  prog_addr;
    prog_data_t  prog_data;
    prog_mask_t  prog_mask;
    bank_t       prog_ba;
    logic        prog_we;
    logic        prom_we;

    // knobs of the acknowledge model
    logic        ack_on;
    int          ack_delay;

    // state of the byte generator
    logic [15:0] lfsr_state;

    rom_dwnld_top #(
        .HEADER     (HDR),
        .PROM_START (PROM_ST),
        .BA1_START  (BA1),
        .BA2_START  (BA2),
        .BA3_START  (BA3)
    ) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    always #5 clk = ~clk;

    ////////////////////
    // SDRAM controller stand-in

    // answers a pending request ack_delay edges after it is seen, with a one cycle ack
    always begin
        @(posedge clk);
        #1;
        if (prog_we && ack_on) begin
            repeat (ack_delay) @(posedge clk);
            #1;
            sdram_ack = 1'b1;
            @(posedge clk);
            #1;
            sdram_ack = 1'b0;
        end
    end

    ////////////////////
    // helpers

    // 16-bit Galois LFSR, one output bit per step
    function automatic logic lfsr_step();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_step()};
        end
        return b;
    endfunction

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input prog_addr_t got, input prog_addr_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input prog_mask_t got, input prog_mask_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input prog_data_t got, input prog_data_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bank(input string name, input bank_t got, input bank_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_run();
        end
    endtask

    // every task starts and ends 1 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // expected port values for a loader address, straight from the map rules
    task automatic ref_map(input ioctl_addr_t addr, output logic prom, output bank_t ba,
                           output prog_addr_t word, output prog_mask_t mask);
        ioctl_addr_t part;
        ioctl_addr_t base;
        ioctl_addr_t eff;
        part = addr - HDR;
        prom = (PROM_ST != ADDR_UNUSED) && (part >= PROM_ST);
        ba   = 2'd0;
        base = '0;
        if (BA3 != ADDR_UNUSED && part >= BA3) begin
            ba   = 2'd3;
            base = BA3;
        end else if (BA2 != ADDR_UNUSED && part >= BA2) begin
            ba   = 2'd2;
            base = BA2;
        end else if (BA1 != ADDR_UNUSED && part >= BA1) begin
            ba   = 2'd1;
            base = BA1;
        end
        eff  = part - base;
        word = prom ? part[21:0] : eff[22:1];
        mask = prom ? 2'b00 : (eff[0] ? 2'b01 : 2'b10);
    endtask

    task automatic drive_byte(input ioctl_addr_t addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        next_cycle();
        ioctl_wr   = 1'b0;
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_bit("prog_we", prog_we, 1'b0);
            check_bit("prom_we", prom_we, 1'b0);
        end
    endtask

    task automatic wait_prog_idle();
        int n;
        n = 0;
        while (prog_we && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (prog_we) begin
            $display("prog_we was not acknowledged within %0d cycles", WAIT_LIMIT);
            stop_run();
        end
    endtask

    // sends one byte and checks the port two cycles later
    task automatic send_and_check(input ioctl_addr_t addr);
        logic [7:0] data;
        logic       is_prom;
        bank_t      exp_ba;
        bank_t      old_ba;
        prog_addr_t exp_word;
        prog_mask_t exp_mask;
        data   = rand_byte();
        old_ba = prog_ba;
        ref_map(addr, is_prom, exp_ba, exp_word, exp_mask);
        drive_byte(addr, data);
        // the byte is inside the decode stage here
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("prom_we", prom_we, 1'b0);
        next_cycle();
        check_bit("prog_we", prog_we, !is_prom);
        check_bit("prom_we", prom_we, is_prom);
        check_addr("prog_addr", prog_addr, exp_word);
        check_mask("prog_mask", prog_mask, exp_mask);
        check_data("prog_data", prog_data, {data, data});
        // PROM bytes leave the bank alone
        check_bank("prog_ba", prog_ba, is_prom ? old_ba : exp_ba);
        if (is_prom) begin
            next_cycle();
            check_bit("prom_we", prom_we, 1'b0);
        end
    endtask

    ////////////////////
    // tests

    // strobes are idle and the payload registers are cleared
    task automatic test_reset();
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("prom_we", prom_we, 1'b0);
        check_addr("prog_addr", prog_addr, 22'h0);
        check_data("prog_data", prog_data, 16'h0);
        check_mask("prog_mask", prog_mask, 2'b00);
        check_bank("prog_ba", prog_ba, 2'd0);
    endtask

    task automatic test_header();
        for (int a = 0; a < HDR; a++) begin
            drive_byte(ioctl_addr_t'(a), rand_byte());
            expect_quiet(4);
        end
    endtask

    // first, second, a middle and the last byte of every bank
    task automatic test_banks();
        int offs [4] = '{0, 1, 'h246, 'hfff};
        for (int b = 0; b < 4; b++) begin
            for (int k = 0; k < 4; k++) begin
                send_and_check(ioctl_addr_t'(b * 'h1000 + offs[k]) + HDR);
                wait_prog_idle();
            end
        end
    endtask

    task automatic test_ack_hold();
        int n;
        n = 0;
        ack_delay = 6;
        send_and_check(BA2 + HDR + 25'h11);
        @(negedge clk);
        while (!sdram_ack && n < WAIT_LIMIT) begin
            check_bit("prog_we", prog_we, 1'b1);
            @(negedge clk);
            n++;
        end
        if (!sdram_ack) begin
            $display("sdram_ack never arrived during the hold test");
            stop_run();
        end
        // the edge after this one samples the ack
        check_bit("prog_we", prog_we, 1'b1);
        @(negedge clk);
        check_bit("prog_we", prog_we, 1'b0);
        next_cycle();
        ack_delay = 2;
    endtask

    task automatic test_prom();
        send_and_check(PROM_ST + HDR);
        send_and_check(PROM_ST + HDR + 25'h1);
        // part address wider than 22 bits is cut to its low bits
        send_and_check(25'h412345 + HDR);
    endtask

    task automatic test_end_download();
        ack_on = 1'b0;
        send_and_check(BA1 + HDR + 25'h55);
        repeat (3) begin
            next_cycle();
            check_bit("prog_we", prog_we, 1'b1);
        end
        downloading = 1'b0;
        next_cycle();
        check_bit("prog_we", prog_we, 1'b0);
        // loader strobes without downloading go nowhere
        drive_byte(BA3 + HDR + 25'h20, rand_byte());
        expect_quiet(4);
        drive_byte(PROM_ST + HDR + 25'h8, rand_byte());
        expect_quiet(4);
        downloading = 1'b1;
        ack_on      = 1'b1;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        sdram_ack   = 1'b0;
        ack_on      = 1'b1;
        ack_delay   = 2;
        lfsr_state  = 16'd48410;
        repeat (16) @(posedge clk);
        #1;
        rst_n       = 1'b1;
        downloading = 1'b1;
        test_reset();
        test_header();
        test_banks();
        test_ack_hold();
        test_prom();
        test_end_download();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== compile.f ====
common/dwnld_map_pkg.sv
common/sdram_prog_pkg.sv
dwnld/rom_region_decode.sv
dwnld/prog_write_port.sv
rtl/rom_dwnld_top.sv
tests/tb_rom_dwnld.sv

// ==== Bender.yml ====
package:
  name: rom_dwnld

sources:
  # shared packages first
  - common/dwnld_map_pkg.sv
  - common/sdram_prog_pkg.sv
  # pipeline stages and top level
  - dwnld/rom_region_decode.sv
  - dwnld/prog_write_port.sv
  - rtl/rom_dwnld_top.sv
  # testbench
  - target: test
    files:
      - tests/tb_rom_dwnld.sv
